/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing
TOP       = tb_fetch
FILELIST  = tb.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Done: no errors"

clean:
	rm -rf obj_dir

/* cpu_pkg.sv */
package cpu_pkg;

    // Datapath and address width
    localparam int XLEN = 32;

    localparam logic [XLEN-1:0] RESET_PC    = 32'h8000_0000;
    localparam logic [XLEN-1:0] INSTR_BYTES = 32'd4;  // No compressed instructions

    // ~~~~~~~~~~~~~~~~~~~~
    // Bus reader states
    localparam logic FETCH_IDLE = 1'b0;
    localparam logic FETCH_READ = 1'b1;

    // Multiply/divide tracker states
    localparam logic [1:0] MD_IDLE = 2'd0;
    localparam logic [1:0] MD_BUSY = 2'd1;
    localparam logic [1:0] MD_DONE = 2'd2;

    // PC sequencer states
    localparam logic [2:0] PC_BOOT          = 3'd0;
    localparam logic [2:0] PC_WAIT_FETCH    = 3'd1;
    localparam logic [2:0] PC_WAIT_HOLD     = 3'd2;
    localparam logic [2:0] PC_WAIT_REDIRECT = 3'd3;
    localparam logic [2:0] PC_ISSUE         = 3'd4;

endpackage

/* fetch_top.sv */
`timescale 1ns/100ps

module fetch_top (
    input  logic                     clk,
    input  logic                     rst_n,
    // Wishbone read master
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic [cpu_pkg::XLEN-1:0] wb_adr,
    input  logic [cpu_pkg::XLEN-1:0] wb_dat_r,
    input  logic                     wb_ack,
    // Execute side
    output logic [cpu_pkg::XLEN-1:0] instr,
    output logic [cpu_pkg::XLEN-1:0] instr_pc,
    output logic                     instr_valid,
    output logic                     instr_muldiv,
    output logic                     instr_jalr,
    input  logic                     muldiv_done,
    input  logic                     redirect_valid,
    input  logic [cpu_pkg::XLEN-1:0] redirect_pc
);

    logic                     fetch_start;
    logic [cpu_pkg::XLEN-1:0] pc;
    logic                     hold;

    // ~~~~~~~~~~~~~~~~~~~~
    // Bus reader and predecode

    fetch_wb i_fetch_wb (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_start  (fetch_start),
        .pc           (pc),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_adr       (wb_adr),
        .instr        (instr),
        .instr_pc     (instr_pc),
        .instr_valid  (instr_valid),
        .instr_muldiv (instr_muldiv),
        .instr_jalr   (instr_jalr)
    );

    stall_track i_stall_track (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr_muldiv (instr_muldiv),
        .muldiv_done  (muldiv_done),
        .hold         (hold)
    );

    // PC register and sequencing
    pc_gen i_pc_gen (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid    (instr_valid),
        .instr_muldiv   (instr_muldiv),
        .instr_jalr     (instr_jalr),
        .hold           (hold),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .pc             (pc),
        .fetch_start    (fetch_start)
    );

endmodule

/* fetch_wb.sv */
`timescale 1ns/100ps

module fetch_wb (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     fetch_start,
    input  logic [cpu_pkg::XLEN-1:0] pc,
    input  logic [cpu_pkg::XLEN-1:0] wb_dat_r,
    input  logic                     wb_ack,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic [cpu_pkg::XLEN-1:0] wb_adr,
    output logic [cpu_pkg::XLEN-1:0] instr,
    output logic [cpu_pkg::XLEN-1:0] instr_pc,
    output logic                     instr_valid,
    output logic                     instr_muldiv,
    output logic                     instr_jalr
);

    logic            state;
    logic            ack_hit;
    isa_pkg::instr_u word;
    logic            is_muldiv;
    logic            is_jalr;

    // ~~~~~~~~~~~~~~~~~~~~
    // Bus machine

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cpu_pkg::FETCH_IDLE;
        end else begin
            case (state)
                cpu_pkg::FETCH_IDLE: begin
                    if (fetch_start) begin
                        state <= cpu_pkg::FETCH_READ;
                    end
                end
                cpu_pkg::FETCH_READ: begin
                    if (wb_ack) begin
                        state <= cpu_pkg::FETCH_IDLE;  // cyc and stb drop next cycle
                    end
                end
                default: state <= cpu_pkg::FETCH_IDLE;
            endcase
        end
    end

    assign wb_cyc  = (state == cpu_pkg::FETCH_READ);
    assign wb_stb  = (state == cpu_pkg::FETCH_READ);
    assign ack_hit = (state == cpu_pkg::FETCH_READ) && wb_ack;

    // Address stays put for the whole cycle
    always_ff @(posedge clk) begin
        if ((state == cpu_pkg::FETCH_IDLE) && fetch_start) begin
            wb_adr <= pc;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Predecode

    assign word = wb_dat_r;

    assign is_muldiv = (word.r.opcode == isa_pkg::OPC_OP) &&
                       (word.r.funct7 == isa_pkg::FUNCT7_MULDIV);
    assign is_jalr   = (word.i.opcode == isa_pkg::OPC_JALR) &&
                       (word.i.funct3 == isa_pkg::FUNCT3_JALR);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_valid  <= 1'b0;
            instr_muldiv <= 1'b0;
            instr_jalr   <= 1'b0;
        end else begin
            instr_valid <= ack_hit;  // Single-cycle pulse
            if (ack_hit) begin
                instr_muldiv <= is_muldiv;
                instr_jalr   <= is_jalr;
            end
        end
    end

    // Word and its address, held until the next ack
    always_ff @(posedge clk) begin
        if (ack_hit) begin
            instr    <= wb_dat_r;
            instr_pc <= wb_adr;
        end
    end

endmodule

/* isa_pkg.sv */
package isa_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Major opcodes
    localparam logic [6:0] OPC_OP   = 7'b0110011;  // Reg-reg ALU, also M extension
    localparam logic [6:0] OPC_JALR = 7'b1100111;

    // Function fields
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;
    localparam logic [2:0] FUNCT3_JALR   = 3'b000;

    // ~~~~~~~~~~~~~~~~~~~~
    // Field layouts of one instruction word

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm;     // Sign-extended by execute
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    // Same 32 bits, two decodings
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

endpackage

/* pc_gen.sv */
`timescale 1ns/100ps

module pc_gen (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     instr_valid,
    input  logic                     instr_muldiv,
    input  logic                     instr_jalr,
    input  logic                     hold,
    input  logic                     redirect_valid,
    input  logic [cpu_pkg::XLEN-1:0] redirect_pc,
    output logic [cpu_pkg::XLEN-1:0] pc,
    output logic                     fetch_start
);

    logic [2:0] state;
    logic       seq_step;  // Step pc when hold releases

    // ~~~~~~~~~~~~~~~~~~~~
    // Fetch sequencing

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= cpu_pkg::PC_BOOT;
            pc       <= cpu_pkg::RESET_PC;
            seq_step <= 1'b0;
        end else begin
            case (state)
                cpu_pkg::PC_BOOT: state <= cpu_pkg::PC_ISSUE;
                cpu_pkg::PC_ISSUE: state <= cpu_pkg::PC_WAIT_FETCH;
                cpu_pkg::PC_WAIT_FETCH: begin
                    if (instr_valid) begin
                        if (instr_jalr) begin
                            state <= cpu_pkg::PC_WAIT_REDIRECT;
                        end else if (instr_muldiv) begin
                            seq_step <= 1'b1;
                            state    <= cpu_pkg::PC_WAIT_HOLD;
                        end else begin
                            pc    <= pc + cpu_pkg::INSTR_BYTES;
                            state <= cpu_pkg::PC_ISSUE;
                        end
                    end
                end
                cpu_pkg::PC_WAIT_HOLD: begin
                    // Tracker raises hold one cycle after the instruction
                    if (!hold) begin
                        if (seq_step) begin
                            pc <= pc + cpu_pkg::INSTR_BYTES;
                        end
                        seq_step <= 1'b0;
                        state    <= cpu_pkg::PC_ISSUE;
                    end
                end
                cpu_pkg::PC_WAIT_REDIRECT: begin
                    if (redirect_valid) begin
                        pc       <= redirect_pc;  // Jump target, no step
                        seq_step <= 1'b0;
                        state    <= cpu_pkg::PC_WAIT_HOLD;
                    end
                end
                default: state <= cpu_pkg::PC_BOOT;
            endcase
        end
    end

    assign fetch_start = (state == cpu_pkg::PC_ISSUE);

endmodule

/* stall_track.sv */
`timescale 1ns/100ps

module stall_track (
    input  logic clk,
    input  logic rst_n,
    input  logic instr_valid,
    input  logic instr_muldiv,
    input  logic muldiv_done,
    output logic hold
);

    logic [1:0] state;
    logic [1:0] state_nxt;
    logic       md_issue;

    assign md_issue = instr_valid && instr_muldiv;

    // ~~~~~~~~~~~~~~~~~~~~
    // Outstanding multiply or divide

    always_comb begin
        state_nxt = state;
        case (state)
            cpu_pkg::MD_IDLE: begin
                if (md_issue) begin
                    // Done already seen here, so skip busy entirely
                    if (muldiv_done) begin
                        state_nxt = cpu_pkg::MD_DONE;
                    end else begin
                        state_nxt = cpu_pkg::MD_BUSY;
                    end
                end
            end
            cpu_pkg::MD_BUSY: begin
                if (muldiv_done) begin
                    state_nxt = cpu_pkg::MD_DONE;
                end
            end
            cpu_pkg::MD_DONE: state_nxt = cpu_pkg::MD_IDLE;  // PC released here
            default:          state_nxt = cpu_pkg::MD_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cpu_pkg::MD_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign hold = (state == cpu_pkg::MD_BUSY);

endmodule

/* tb.f */
cpu_pkg.sv
isa_pkg.sv
fetch_wb.sv
stall_track.sv
pc_gen.sv
fetch_top.sv
tb_clk_gen.sv
tb_fetch.sv

/* tb_clk_gen.sv */
`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // Reset held for 10 cycles
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* tb_fetch.sv */
`timescale 1ns/100ps

module tb_fetch;

    logic                     clk;
    logic                     rst_n;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic [cpu_pkg::XLEN-1:0] wb_adr;
    logic [cpu_pkg::XLEN-1:0] wb_dat_r = '0;
    logic                     wb_ack = 1'b0;
    logic [cpu_pkg::XLEN-1:0] instr;
    logic [cpu_pkg::XLEN-1:0] instr_pc;
    logic                     instr_valid;
    logic                     instr_muldiv;
    logic                     instr_jalr;
    logic                     muldiv_done = 1'b0;
    logic                     redirect_valid = 1'b0;
    logic [cpu_pkg::XLEN-1:0] redirect_pc = '0;

    logic [31:0] mem [logic [31:0]];  // Sparse instruction memory
    logic [31:0] next_pc;
    logic        armed = 1'b0;
    int unsigned delay = 0;
    int unsigned wait_states;
    logic        prev_req = 1'b0;
    logic [31:0] prev_adr = '0;

    tb_clk_gen i_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    fetch_top i_fetch_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_adr         (wb_adr),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack),
        .instr          (instr),
        .instr_pc       (instr_pc),
        .instr_valid    (instr_valid),
        .instr_muldiv   (instr_muldiv),
        .instr_jalr     (instr_jalr),
        .muldiv_done    (muldiv_done),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Reporting and instruction words

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else report_fail($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [6:0] opc);
        isa_pkg::instr_u w;
        w.r.funct7 = f7;
        w.r.rs2    = 5'd2;
        w.r.rs1    = 5'd1;
        w.r.funct3 = f3;
        w.r.rd     = 5'd3;
        w.r.opcode = opc;
        return w;
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [6:0] opc);
        isa_pkg::instr_u w;
        w.i.imm    = imm;
        w.i.rs1    = 5'd5;
        w.i.funct3 = f3;
        w.i.rd     = 5'd1;
        w.i.opcode = opc;
        return w;
    endfunction

    function automatic logic [31:0] addi_word();
        return i_word(12'($urandom), 3'b000, 7'b0010011);
    endfunction

    // Unloaded words are ADDI with a hash of the address
    function automatic logic [31:0] mem_read(input logic [31:0] a);
        logic [31:0] h;
        h = a * 32'h9E37_79B1;
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {h[31:7], 7'b0010011};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Wishbone slave, 0 to 3 wait states

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
            armed  <= 1'b0;
            delay  <= 0;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;
            armed  <= 1'b0;
        end else if (wb_stb) begin
            if (!armed) begin
                wait_states = $urandom % 4;
                if (wait_states == 0) begin
                    wb_ack   <= 1'b1;
                    wb_dat_r <= mem_read(wb_adr);
                end else begin
                    armed <= 1'b1;
                    delay <= wait_states - 1;
                end
            end else if (delay == 0) begin
                wb_ack   <= 1'b1;
                wb_dat_r <= mem_read(wb_adr);
            end else begin
                delay <= delay - 1;
            end
        end
    end

    // Request must stay put until ack
    always @(posedge clk) begin
        if (rst_n && prev_req) begin
            assert (wb_stb && wb_cyc)
            else report_fail("wb_stb or wb_cyc dropped before ack");
            check_value("wb_adr", wb_adr, prev_adr);
        end
        if (rst_n) begin
            assert (wb_cyc === wb_stb)
            else report_fail($sformatf("mismatch wb_cyc: got %h expected %h", wb_cyc, wb_stb));
        end
        prev_req <= wb_stb && !wb_ack;
        prev_adr <= wb_adr;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Fetch checks

    // One read at exp_addr, ending on its instr_valid sample
    task automatic fetch_expect(input logic [31:0] exp_addr, input logic [31:0] exp_word,
                                input logic exp_muldiv, input logic exp_jalr);
        int n;
        n = 0;
        while (!wb_stb) begin
            @(posedge clk);
            n++;
            if (n > 50) report_fail("timeout: no bus read started");
        end
        check_value("wb_adr", wb_adr, exp_addr);
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > 50) report_fail("timeout: no instr_valid after bus read");
        end while (!instr_valid);
        check_value("instr", instr, exp_word);
        check_value("instr_pc", instr_pc, exp_addr);
        check_value("instr_muldiv", 32'(instr_muldiv), 32'(exp_muldiv));
        check_value("instr_jalr", 32'(instr_jalr), 32'(exp_jalr));
    endtask

    // Plain step: strobe rises 2 cycles after instr_valid
    task automatic plain_gap();
        @(posedge clk);
        check_value("wb_stb", 32'(wb_stb), 32'd0);
        @(posedge clk);
        check_value("wb_stb", 32'(wb_stb), 32'd1);
    endtask

    // Called on the edge that sampled done or redirect
    task automatic expect_restart(input logic [31:0] exp_addr);
        repeat (2) begin
            @(posedge clk);
            check_value("wb_stb", 32'(wb_stb), 32'd0);
        end
        @(posedge clk);
        check_value("wb_stb", 32'(wb_stb), 32'd1);
        check_value("wb_adr", wb_adr, exp_addr);
    endtask

    task automatic idle_cycles(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            check_value("wb_stb", 32'(wb_stb), 32'd0);
        end
    endtask

    task automatic test_reset_seq();
        logic [31:0] words [4];
        next_pc = cpu_pkg::RESET_PC;
        for (int k = 0; k < 4; k++) begin
            words[k] = (k == 0) ? r_word(7'b0, 3'b000, isa_pkg::OPC_OP) : addi_word();
            mem[next_pc + cpu_pkg::INSTR_BYTES * 32'(k)] = words[k];
        end
        for (int k = 0; k < 4; k++) begin
            fetch_expect(next_pc, words[k], 1'b0, 1'b0);
            if (k < 3) plain_gap();
            next_pc = next_pc + cpu_pkg::INSTR_BYTES;
        end
    endtask

    task automatic test_backpressure();
        logic [31:0] w;
        for (int k = 0; k < 8; k++) begin
            w = addi_word();
            mem[next_pc] = w;
            fetch_expect(next_pc, w, 1'b0, 1'b0);
            next_pc = next_pc + cpu_pkg::INSTR_BYTES;
        end
    endtask

    task automatic test_muldiv_hold();
        logic [31:0] w;
        w = r_word(isa_pkg::FUNCT7_MULDIV, 3'b000, isa_pkg::OPC_OP);  // MUL
        mem[next_pc] = w;
        fetch_expect(next_pc, w, 1'b1, 1'b0);
        idle_cycles(7);
        muldiv_done <= 1'b1;
        @(posedge clk);
        muldiv_done <= 1'b0;
        next_pc = next_pc + cpu_pkg::INSTR_BYTES;
        w = addi_word();
        mem[next_pc] = w;
        expect_restart(next_pc);
        fetch_expect(next_pc, w, 1'b0, 1'b0);
        next_pc = next_pc + cpu_pkg::INSTR_BYTES;
    endtask

    task automatic test_jalr_redirect();
        logic [31:0] w;
        // Stray redirect while a plain fetch is issued
        redirect_valid <= 1'b1;
        redirect_pc    <= 32'hDEAD_BEE0;
        @(posedge clk);
        redirect_valid <= 1'b0;
        w = i_word(12'h010, 3'b000, isa_pkg::OPC_JALR);
        mem[next_pc] = w;
        fetch_expect(next_pc, w, 1'b0, 1'b1);
        idle_cycles(5);
        mem[32'h8000_1000] = r_word(isa_pkg::FUNCT7_MULDIV, 3'b100, isa_pkg::OPC_OP);  // DIV
        redirect_valid <= 1'b1;
        redirect_pc    <= 32'h8000_1000;
        @(posedge clk);
        redirect_valid <= 1'b0;
        redirect_pc    <= 32'h1234_5678;
        next_pc = 32'h8000_1000;
        expect_restart(next_pc);
    endtask

    task automatic test_target_div();
        logic [31:0] w;
        logic [31:0] seq_words [2];
        w = r_word(isa_pkg::FUNCT7_MULDIV, 3'b100, isa_pkg::OPC_OP);  // DIV at the target
        fetch_expect(next_pc, w, 1'b1, 1'b0);
        idle_cycles(2);
        redirect_valid <= 1'b1;  // Ignored during hold
        redirect_pc    <= 32'h0000_0040;
        @(posedge clk);
        redirect_valid <= 1'b0;
        idle_cycles(2);
        muldiv_done <= 1'b1;
        @(posedge clk);
        muldiv_done <= 1'b0;
        next_pc = next_pc + cpu_pkg::INSTR_BYTES;
        for (int k = 0; k < 2; k++) begin
            seq_words[k] = addi_word();
            mem[next_pc + cpu_pkg::INSTR_BYTES * 32'(k)] = seq_words[k];
        end
        expect_restart(next_pc);
        for (int k = 0; k < 2; k++) begin
            fetch_expect(next_pc, seq_words[k], 1'b0, 1'b0);
            if (k == 0) plain_gap();
            next_pc = next_pc + cpu_pkg::INSTR_BYTES;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Main sequence

    initial begin
        int n;
        void'($urandom(32'h2080));
        n = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            n++;
            if (n > 30) report_fail("timeout: reset never released");
        end
        test_reset_seq();
        test_backpressure();
        test_muldiv_hold();
        test_jalr_redirect();
        test_target_div();
        repeat (3) @(posedge clk);
        $display("Done: no errors");
        $finish;
    end

endmodule
